//--- src.f
spi_pkg.sv
spi_cmd_dispatch.sv
spi_lane.sv
spi_rsp_collect.sv
spi_multi_top.sv
tb_spi_multi.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_spi_multi
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_spi_multi.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spi_multi
   import spi_pkg::*;
();

   localparam int NUM_LANES      = DEF_NUM_LANES;
   localparam int CLK_DIV        = DEF_CLK_DIV;
   localparam int XFER_WIDTH     = DEF_XFER_WIDTH;
   localparam int LANE_W         = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
   localparam int CLK_PERIOD     = 40;
   localparam int SEED           = 76338;
   localparam int NUM_RANDOM     = 60;
   localparam int NUM_CMDS       = NUM_RANDOM + 10;   // Directed tests send 10
   localparam int CMD_CYCLES     = 2 * CLK_DIV * XFER_WIDTH + 40;
   localparam int TIMEOUT_CYCLES = 20 + NUM_CMDS * CMD_CYCLES;
   localparam int RDY_ALWAYS     = 0;
   localparam int RDY_HOLD       = 1;
   localparam int RDY_RANDOM     = 2;

   logic                  clk_i;
   logic                  rst_i;
   logic                  cmd_valid_i;
   wire                   cmd_ready_o;
   logic [LANE_W-1:0]     cmd_lane_i;
   logic [XFER_WIDTH-1:0] cmd_data_i;
   wire                   rsp_valid_o;
   logic                  rsp_ready_i;
   wire  [LANE_W-1:0]     rsp_lane_o;
   wire  [XFER_WIDTH-1:0] rsp_data_o;
   wire  [NUM_LANES-1:0]  spi_clk_o;
   wire  [NUM_LANES-1:0]  spi_ss_o;
   wire  [NUM_LANES-1:0]  spi_mosi_o;
   wire  [NUM_LANES-1:0]  spi_miso_i;

   logic [XFER_WIDTH-1:0] exp_q [NUM_LANES][$];   // Expected responses per lane
   logic [XFER_WIDTH-1:0] cmd_sent [NUM_LANES];    // Last word commanded per lane
   logic [XFER_WIDTH-1:0] hist_word [NUM_LANES];
   logic                  hist_valid [NUM_LANES];
   int unsigned           rnd_state;
   int                    ready_mode = RDY_ALWAYS;
   int                    cycle_cnt = 0;
   int                    cmd_cnt = 0;
   int                    rsp_cnt = 0;

   spi_multi_top DUT (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_o (cmd_ready_o),
      .cmd_lane_i  (cmd_lane_i),
      .cmd_data_i  (cmd_data_i),
      .rsp_valid_o (rsp_valid_o),
      .rsp_ready_i (rsp_ready_i),
      .rsp_lane_o  (rsp_lane_o),
      .rsp_data_o  (rsp_data_o),
      .spi_clk_o   (spi_clk_o),
      .spi_ss_o    (spi_ss_o),
      .spi_mosi_o  (spi_mosi_o),
      .spi_miso_i  (spi_miso_i)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // ==============================
   // Error reporting and helpers
   // ==============================

   task automatic halt_run();
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic mismatch_error(input string sig, input logic [31:0] exp, input logic [31:0] got);
      $display("[ERROR] %0t: %s expected 0x%0h, got 0x%0h", $time, sig, exp, got);
      halt_run();
   endtask

   task automatic plain_error(input string msg);
      $display("Error at %0t: %s", $time, msg);
      halt_run();
   endtask

   function automatic int unsigned lcg_next(input int unsigned s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic int unsigned rand_val();
      rnd_state = lcg_next(rnd_state);
      return rnd_state >> 16;   // Upper bits are the better ones
   endfunction

   // Slave answers with the inverse of its previous word or zero at first
   function automatic logic [XFER_WIDTH-1:0] expected_rsp(input int lane,
                                                          input logic [XFER_WIDTH-1:0] data);
      logic [XFER_WIDTH-1:0] result;
      result = hist_valid[lane] ? ~hist_word[lane] : '0;
      hist_word[lane]  = data;
      hist_valid[lane] = 1'b1;
      return result;
   endfunction

   function automatic int total_pending();
      int n;
      n = 0;
      for (int l = 0; l < NUM_LANES; l++)
         n += exp_q[l].size();
      return n;
   endfunction

   // Called at a falling edge and returns at the falling edge after the transfer
   task automatic send_cmd(input int lane, input logic [XFER_WIDTH-1:0] data);
      cmd_valid_i = 1'b1;
      cmd_lane_i  = LANE_W'(lane);
      cmd_data_i  = data;
      #(CLK_PERIOD / 4);
      while (!cmd_ready_o)
      begin
         @(negedge clk_i);
         #(CLK_PERIOD / 4);
      end
      cmd_sent[lane] = data;   // Transfer on the coming rising edge
      exp_q[lane].push_back(expected_rsp(lane, data));
      cmd_cnt++;
      @(negedge clk_i);
   endtask

   task automatic end_cmds();
      cmd_valid_i = 1'b0;
   endtask

   task automatic probe_ready(input int lane, output logic rdy);
      cmd_lane_i = LANE_W'(lane);
      #(CLK_PERIOD / 4);
      rdy = cmd_ready_o;
      @(negedge clk_i);
   endtask

   task automatic wait_xfer_done(input int lane);
      while (spi_ss_o[lane])
         @(negedge clk_i);
   endtask

   task automatic wait_drained();
      while (total_pending() != 0 || spi_ss_o != '0)
         @(negedge clk_i);
   endtask

   task automatic set_ready_mode(input int mode);
      @(posedge clk_i);
      ready_mode = mode;
      @(negedge clk_i);
   endtask

   task automatic check_reset_state();
      #(CLK_PERIOD / 4);
      assert (spi_ss_o == '0) else mismatch_error("spi_ss_o", 0, 32'(spi_ss_o));
      assert (spi_clk_o == '0) else mismatch_error("spi_clk_o", 0, 32'(spi_clk_o));
      assert (spi_mosi_o == '0) else mismatch_error("spi_mosi_o", 0, 32'(spi_mosi_o));
      assert (rsp_valid_o == 1'b0) else mismatch_error("rsp_valid_o", 0, 32'(rsp_valid_o));
      assert (cmd_ready_o == 1'b1) else mismatch_error("cmd_ready_o", 1, 32'(cmd_ready_o));
      @(negedge clk_i);
   endtask

   // ==============================
   // SPI slave models
   // ==============================

   for (genvar g = 0; g < NUM_LANES; g++)
   begin : g_slave
      logic [XFER_WIDTH-1:0] tx_q;
      logic [XFER_WIDTH-1:0] rx_q;
      logic [XFER_WIDTH-1:0] last_rx;
      logic                  has_prev;

      assign spi_miso_i[g] = tx_q[XFER_WIDTH-1];   // MSB first

      initial
      begin
         tx_q     = '0;
         rx_q     = '0;
         last_rx  = '0;
         has_prev = 1'b0;
         forever
         begin
            @(posedge spi_ss_o[g]);
            tx_q = has_prev ? ~last_rx : '0;
            for (int b = 0; b < XFER_WIDTH; b++)
            begin
               @(posedge spi_clk_o[g]);
               assert (spi_ss_o[g])
               else
                  plain_error($sformatf("lane %0d clocked with select low, state %s",
                                        g, DUT.g_lane[g].u_lane.state_q.name()));
               rx_q = {rx_q[XFER_WIDTH-2:0], spi_mosi_o[g]};
               @(negedge spi_clk_o[g]);
               tx_q = {tx_q[XFER_WIDTH-2:0], 1'b0};
            end
            wait (!spi_ss_o[g]);
            assert (rx_q == cmd_sent[g])
            else
               mismatch_error($sformatf("spi_mosi_o[%0d] word", g),
                              32'(cmd_sent[g]), 32'(rx_q));
            last_rx  = rx_q;
            has_prev = 1'b1;
         end
      end
   end

   // Response ready pattern
   initial
   begin
      int unsigned rdy_state;
      rdy_state   = SEED;
      rsp_ready_i = 1'b0;
      forever
      begin
         @(negedge clk_i);
         rdy_state = lcg_next(rdy_state);
         case (ready_mode)
            RDY_HOLD:   rsp_ready_i = 1'b0;
            RDY_RANDOM: rsp_ready_i = (rdy_state[21:20] != 2'b00);
            default:    rsp_ready_i = 1'b1;
         endcase
      end
   end

   // Compare each response handshake with the lane's queue
   initial
   begin
      int                    lane;
      logic [XFER_WIDTH-1:0] exp_word;
      forever
      begin
         @(negedge clk_i);
         #(CLK_PERIOD / 4);
         if (rsp_valid_o && rsp_ready_i)
         begin
            lane = int'(rsp_lane_o);
            assert (exp_q[lane].size() > 0)
            else
               plain_error($sformatf("response on lane %0d with no command pending", lane));
            exp_word = exp_q[lane].pop_front();
            assert (rsp_data_o == exp_word)
            else
               mismatch_error($sformatf("rsp_data_o (lane %0d)", lane),
                              32'(exp_word), 32'(rsp_data_o));
            rsp_cnt++;
         end
      end
   end

   always @(posedge clk_i)
   begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         plain_error($sformatf("timeout after %0d cycles", cycle_cnt));
   end

   // ==============================
   // Stimulus
   // ==============================

   initial
   begin
      int   lane;
      int   held;
      logic rdy;
      rst_i       = 1'b1;
      cmd_valid_i = 1'b0;
      cmd_lane_i  = '0;
      cmd_data_i  = '0;
      rnd_state   = SEED;
      for (int l = 0; l < NUM_LANES; l++)
      begin
         hist_valid[l] = 1'b0;
         hist_word[l]  = '0;
         cmd_sent[l]   = '0;
      end
      repeat (10) @(negedge clk_i);
      rst_i = 1'b0;
      check_reset_state();

      // Two words on lane 0 where the first answers zero
      send_cmd(0, XFER_WIDTH'(8'hA5));
      send_cmd(0, XFER_WIDTH'(8'h3C));
      end_cmds();
      wait_drained();

      // One word per lane back to back
      for (int l = 0; l < NUM_LANES; l++)
         send_cmd(l, XFER_WIDTH'(rand_val()));
      assert ($countones(spi_ss_o) > 1) else plain_error("lanes did not shift together");
      end_cmds();
      wait_drained();

      // Back-pressure with only the last lane left free
      set_ready_mode(RDY_HOLD);
      for (int l = 0; l < NUM_LANES - 1; l++)
         send_cmd(l, XFER_WIDTH'(rand_val()));
      end_cmds();
      for (int l = 0; l < NUM_LANES - 1; l++)
         wait_xfer_done(l);
      while (!rsp_valid_o)
         @(negedge clk_i);
      held = 0;
      for (int l = 0; l < NUM_LANES - 1; l++)
      begin
         probe_ready(l, rdy);
         if (!rdy)
            held++;
      end
      assert (held == NUM_LANES - 2)   // One result sits in the output register
      else
         mismatch_error("lanes with cmd_ready_o low", 32'(NUM_LANES - 2), 32'(held));
      send_cmd(NUM_LANES - 1, XFER_WIDTH'(rand_val()));
      end_cmds();
      wait_xfer_done(NUM_LANES - 1);
      set_ready_mode(RDY_ALWAYS);
      wait_drained();

      // Random run
      set_ready_mode(RDY_RANDOM);
      for (int n = 0; n < NUM_RANDOM; n++)
      begin
         lane = int'(rand_val() % NUM_LANES);
         send_cmd(lane, XFER_WIDTH'(rand_val()));
      end
      end_cmds();
      wait_drained();

      // A duplicate would still sit in the output register
      if (!rsp_valid_o)
      begin
         $display("TESTS PASSED");
         $finish;
      end
      else
         plain_error($sformatf("extra response after %0d of %0d commands answered",
                               rsp_cnt, cmd_cnt));
   end

endmodule

`default_nettype wire

//--- spi_multi_top.sv
`timescale 1ns/10ps
`default_nettype none

module spi_multi_top
   import spi_pkg::*;
#(
   parameter int  NUM_LANES  = DEF_NUM_LANES,
   parameter int  CLK_DIV    = DEF_CLK_DIV,
   parameter int  XFER_WIDTH = DEF_XFER_WIDTH,
   localparam int LANE_W     = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
)
(
   input  wire                    clk_i,
   input  wire                    rst_i,

   // Host command port
   input  wire                    cmd_valid_i,
   output logic                   cmd_ready_o,
   input  wire  [LANE_W-1:0]      cmd_lane_i,
   input  wire  [XFER_WIDTH-1:0]  cmd_data_i,

   // Host response port
   output logic                   rsp_valid_o,
   input  wire                    rsp_ready_i,
   output logic [LANE_W-1:0]      rsp_lane_o,
   output logic [XFER_WIDTH-1:0]  rsp_data_o,

   // SPI pins, one bit per lane
   output logic [NUM_LANES-1:0]   spi_clk_o,
   output logic [NUM_LANES-1:0]   spi_ss_o,
   output logic [NUM_LANES-1:0]   spi_mosi_o,
   input  wire  [NUM_LANES-1:0]   spi_miso_i
);

   logic [NUM_LANES-1:0]            lane_start;
   logic [NUM_LANES*XFER_WIDTH-1:0] lane_data;
   logic [NUM_LANES-1:0]            lane_idle;
   logic [NUM_LANES-1:0]            res_valid;
   logic [NUM_LANES-1:0]            res_ready;
   logic [NUM_LANES*XFER_WIDTH-1:0] res_data;

   spi_cmd_dispatch #(
      .NUM_LANES  (NUM_LANES),
      .XFER_WIDTH (XFER_WIDTH)
   ) u_dispatch (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_ready_o  (cmd_ready_o),
      .cmd_lane_i   (cmd_lane_i),
      .cmd_data_i   (cmd_data_i),
      .lane_idle_i  (lane_idle),
      .lane_start_o (lane_start),
      .lane_data_o  (lane_data)
   );

   // One shift engine per lane
   for (genvar g = 0; g < NUM_LANES; g++)
   begin : g_lane
      spi_lane #(
         .CLK_DIV    (CLK_DIV),
         .XFER_WIDTH (XFER_WIDTH)
      ) u_lane (
         .clk_i       (clk_i),
         .rst_i       (rst_i),
         .start_i     (lane_start[g]),
         .data_i      (lane_data[g*XFER_WIDTH +: XFER_WIDTH]),
         .idle_o      (lane_idle[g]),
         .res_valid_o (res_valid[g]),
         .res_ready_i (res_ready[g]),
         .res_data_o  (res_data[g*XFER_WIDTH +: XFER_WIDTH]),
         .spi_clk_o   (spi_clk_o[g]),
         .spi_ss_o    (spi_ss_o[g]),
         .spi_mosi_o  (spi_mosi_o[g]),
         .spi_miso_i  (spi_miso_i[g])
      );
   end

   spi_rsp_collect #(
      .NUM_LANES  (NUM_LANES),
      .XFER_WIDTH (XFER_WIDTH)
   ) u_collect (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .res_valid_i (res_valid),
      .res_ready_o (res_ready),
      .res_data_i  (res_data),
      .rsp_valid_o (rsp_valid_o),
      .rsp_ready_i (rsp_ready_i),
      .rsp_lane_o  (rsp_lane_o),
      .rsp_data_o  (rsp_data_o)
   );

endmodule

`default_nettype wire

//--- spi_rsp_collect.sv
`timescale 1ns/10ps
`default_nettype none

module spi_rsp_collect
   import spi_pkg::*;
#(
   parameter int  NUM_LANES  = DEF_NUM_LANES,
   parameter int  XFER_WIDTH = DEF_XFER_WIDTH,
   localparam int LANE_W     = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
)
(
   input  wire                             clk_i,
   input  wire                             rst_i,

   // Lane results
   input  wire  [NUM_LANES-1:0]            res_valid_i,
   output logic [NUM_LANES-1:0]            res_ready_o,
   input  wire  [NUM_LANES*XFER_WIDTH-1:0] res_data_i,

   // Host response port
   output logic                            rsp_valid_o,
   input  wire                             rsp_ready_i,
   output logic [LANE_W-1:0]               rsp_lane_o,
   output logic [XFER_WIDTH-1:0]           rsp_data_o
);

   logic [LANE_W-1:0]    ptr_q;      // Highest priority lane
   logic                 load_en;
   logic                 gnt_any;
   logic [LANE_W-1:0]    gnt_lane;
   logic [NUM_LANES-1:0] gnt_vec;
   int                   scan_idx;

   // Output register free or draining this cycle
   assign load_en = ~rsp_valid_o | rsp_ready_i;

   // Round-robin search starting at the pointer
   always_comb
   begin
      gnt_any  = 1'b0;
      gnt_lane = '0;
      gnt_vec  = '0;
      scan_idx = 0;
      for (int i = 0; i < NUM_LANES; i++)
      begin
         scan_idx = (int'(ptr_q) + i) % NUM_LANES;
         if (!gnt_any && res_valid_i[scan_idx])
         begin
            gnt_any  = 1'b1;
            gnt_lane = LANE_W'(scan_idx);
         end
      end
      if (gnt_any)
         gnt_vec[gnt_lane] = 1'b1;
   end

   assign res_ready_o = gnt_vec & {NUM_LANES{load_en}};

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         rsp_valid_o <= 1'b0;
         ptr_q       <= '0;
      end
      else if (load_en)
      begin
         rsp_valid_o <= gnt_any;
         if (gnt_any)   // Next search starts past the winner
            ptr_q <= (gnt_lane == LANE_W'(NUM_LANES - 1)) ? '0 : gnt_lane + 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (load_en && gnt_any)
      begin
         rsp_lane_o <= gnt_lane;
         rsp_data_o <= res_data_i[gnt_lane*XFER_WIDTH +: XFER_WIDTH];
      end
   end

   // ==============================
   // Checks
   // ==============================

   a_grant_onehot: assert property (
      @(posedge clk_i) disable iff (rst_i)
      $onehot0(res_ready_o)
   )
   else
      $error("more than one lane granted");

endmodule

`default_nettype wire

//--- spi_lane.sv
`timescale 1ns/10ps
`default_nettype none

module spi_lane
   import spi_pkg::*;
#(
   parameter int CLK_DIV    = DEF_CLK_DIV,
   parameter int XFER_WIDTH = DEF_XFER_WIDTH
)
(
   input  wire                    clk_i,
   input  wire                    rst_i,

   // Command side
   input  wire                    start_i,
   input  wire  [XFER_WIDTH-1:0]  data_i,
   output logic                   idle_o,

   // Result side
   output logic                   res_valid_o,
   input  wire                    res_ready_i,
   output logic [XFER_WIDTH-1:0]  res_data_o,

   // SPI pins
   output logic                   spi_clk_o,
   output logic                   spi_ss_o,
   output logic                   spi_mosi_o,
   input  wire                    spi_miso_i
);

   localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
   localparam int BIT_W = $clog2(XFER_WIDTH + 1);

   lane_state_e           state_q;
   logic [DIV_W-1:0]      div_cnt_q;
   logic                  div_clk_q;       // Internal serial clock
   logic                  div_clk_prev_q;
   logic [BIT_W-1:0]      bit_cnt_q;       // Falling edges seen so far
   logic [XFER_WIDTH-1:0] shift_q;
   logic                  div_rise;
   logic                  div_fall;

   // ==============================
   // Clock divider
   // ==============================

   // Runs only while shifting, parked low otherwise
   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         div_cnt_q <= '0;
         div_clk_q <= 1'b0;
      end
      else if (state_q == LANE_SHIFT)
      begin
         if (div_cnt_q == DIV_W'(CLK_DIV - 1))
         begin
            div_cnt_q <= '0;
            div_clk_q <= ~div_clk_q;
         end
         else
            div_cnt_q <= div_cnt_q + 1'b1;
      end
      else
      begin
         div_cnt_q <= '0;
         div_clk_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
         div_clk_prev_q <= 1'b0;
      else
         div_clk_prev_q <= div_clk_q;
   end

   assign div_rise = ~div_clk_prev_q & div_clk_q;
   assign div_fall = div_clk_prev_q & ~div_clk_q;

   // ==============================
   // Lane FSM and shifter
   // ==============================

   always_ff @(posedge clk_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         state_q   <= LANE_IDLE;
         bit_cnt_q <= '0;
         shift_q   <= '0;   // Keeps MOSI low out of reset
         spi_clk_o <= 1'b0;
         spi_ss_o  <= 1'b0;
      end
      else
      begin
         case (state_q)
            LANE_IDLE:
            begin
               if (start_i)
               begin
                  shift_q   <= data_i;
                  bit_cnt_q <= '0;
                  spi_ss_o  <= 1'b1;
                  state_q   <= LANE_SHIFT;
               end
            end
            LANE_SHIFT:
            begin
               if (div_rise)
                  spi_clk_o <= 1'b1;
               else if (div_fall)
               begin
                  // Sample MISO and move the next bit onto MOSI
                  spi_clk_o <= 1'b0;
                  shift_q   <= {shift_q[XFER_WIDTH-2:0], spi_miso_i};
                  bit_cnt_q <= bit_cnt_q + 1'b1;
                  if (bit_cnt_q == BIT_W'(XFER_WIDTH - 1))
                  begin
                     spi_ss_o <= 1'b0;
                     state_q  <= LANE_HOLD;
                  end
               end
            end
            LANE_HOLD:
            begin
               if (res_ready_i)
                  state_q <= LANE_IDLE;
            end
            default: state_q <= LANE_IDLE;
         endcase
      end
   end

   assign spi_mosi_o  = shift_q[XFER_WIDTH-1];
   assign idle_o      = (state_q == LANE_IDLE);
   assign res_valid_o = (state_q == LANE_HOLD);
   assign res_data_o  = shift_q;   // Received word

   // ==============================
   // Checks
   // ==============================

   a_ss_in_shift: assert property (
      @(posedge clk_i) disable iff (rst_i)
      spi_ss_o == (state_q == LANE_SHIFT)
   )
   else
      $error("select out of step with lane state %s", state_q.name());

   // Result stays put until the collector takes it
   a_res_hold: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_data_o))
   )
   else
      $error("lane result dropped without handshake");

endmodule

`default_nettype wire

//--- spi_cmd_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module spi_cmd_dispatch
   import spi_pkg::*;
#(
   parameter int  NUM_LANES  = DEF_NUM_LANES,
   parameter int  XFER_WIDTH = DEF_XFER_WIDTH,
   localparam int LANE_W     = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
)
(
   input  wire                            clk_i,
   input  wire                            rst_i,

   // Host command port
   input  wire                            cmd_valid_i,
   output logic                           cmd_ready_o,
   input  wire  [LANE_W-1:0]              cmd_lane_i,
   input  wire  [XFER_WIDTH-1:0]          cmd_data_i,

   // Lane side
   input  wire  [NUM_LANES-1:0]           lane_idle_i,
   output logic [NUM_LANES-1:0]           lane_start_o,
   output logic [NUM_LANES*XFER_WIDTH-1:0] lane_data_o
);

   logic                 lane_ok;   // Lane number addresses a real lane
   logic [NUM_LANES-1:0] lane_sel;
   logic                 cmd_xfer;

   assign lane_ok = (cmd_lane_i < NUM_LANES);

   // One-hot lane decode
   always_comb
   begin
      lane_sel = '0;
      if (lane_ok)
         lane_sel[cmd_lane_i] = 1'b1;
   end

   // Ready follows the idle flag of the addressed lane
   assign cmd_ready_o = lane_ok & (|(lane_sel & lane_idle_i));
   assign cmd_xfer    = cmd_valid_i & cmd_ready_o;

   assign lane_start_o = lane_sel & {NUM_LANES{cmd_xfer}};
   assign lane_data_o  = {NUM_LANES{cmd_data_i}};   // Only the started lane loads it

   // ==============================
   // Checks
   // ==============================

   // A start only goes to an idle lane, and that lane has left idle one cycle later
   a_start_to_idle: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (|lane_start_o) |->
         ((lane_start_o & ~lane_idle_i) == '0) ##1
         (($past(lane_start_o) & lane_idle_i) == '0)
   )
   else
      $error("lane start to a busy lane, or lane stayed idle");

   a_lane_range: assert property (
      @(posedge clk_i) disable iff (rst_i)
      cmd_valid_i |-> lane_ok
   )
   else
      $error("command lane %0d out of range", cmd_lane_i);

endmodule

`default_nettype wire

//--- spi_pkg.sv
`default_nettype none

package spi_pkg;

   // ==============================
   // Lane FSM
   // ==============================

   // One SPI lane either waits, shifts, or holds its received word
   typedef enum logic [1:0]
   {
      LANE_IDLE  = 2'b00,  // Ready for a command
      LANE_SHIFT = 2'b01,  // Select high, bits moving
      LANE_HOLD  = 2'b10   // Result waits for the collector
   } lane_state_e;

   // ==============================
   // Default sizing
   // ==============================

   // Number of independent SPI lanes
   localparam int DEF_NUM_LANES = 4;

   // System clocks per serial half period
   localparam int DEF_CLK_DIV = 4;

   // Word width, shifted MSB first
   localparam int DEF_XFER_WIDTH = 8;

endpackage

`default_nettype wire
